//--- hdl/ring_mem_pkg.sv
/* Ring memory node package
   Shared widths, ring packet operations and controller states */
package ring_mem_pkg;

	// Width of one word in the backing store and on the fetch port
	localparam int WORD_BITS = 32;

	// Byte address width carried on the ring and on the fetch port
	localparam int ADDR_BITS = 32;

	// Width of the destination node number in a packet
	localparam int NODE_BITS = 4;

	// Coherence operations carried by a ring packet
	// The fourth code is not used by any sender
	typedef enum logic [1:0]
	{
		OP_READ_SHARED      = 2'd0,
		OP_WRITE_INVALIDATE = 2'd1,
		OP_L2_WRITEBACK     = 2'd2
	} ring_op_t;

	// Line transfer controller states
	// IDLE waits for a strobe, TRANSFER moves one word per cycle,
	// FINISH covers the last read word arriving from the store
	typedef enum logic [1:0]
	{
		ST_IDLE     = 2'd0,
		ST_TRANSFER = 2'd1,
		ST_FINISH   = 2'd2
	} mem_state_t;

endpackage

//--- hdl/ring_mem_ctrl.sv
/* Line transfer controller
   Accepts a packet strobe, walks the line through the store and raises the reply strobe */
module ring_mem_ctrl
	import ring_mem_pkg::*;
	#(parameter int LINE_WORDS = 16)
	(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     pkt_valid,
	input  ring_op_t pkt_op,
	input  logic     last,
	output logic     start,
	output logic     run,
	output logic     capture,
	output logic     load,
	output logic     op_write,
	output logic     store_we,
	output logic     resp_valid
	);

	mem_state_t state;

	// A line of one word would leave the beat counter without any bits
	if (LINE_WORDS < 2)
	begin : g_line_check
		$error("ring_mem_ctrl needs at least two words per line");
	end

	// A packet is only taken while idle
	// One that arrives during a transfer is dropped here and flagged by the assertions
	assign start   = pkt_valid && (state == ST_IDLE);
	assign capture = start;

	// The beat counter steps for every cycle spent in transfer
	assign run = (state == ST_TRANSFER);

	// Writebacks push one buffered word into the store per beat
	assign store_we = run && op_write;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state      <= ST_IDLE;
			op_write   <= 1'b0;
			load       <= 1'b0;
			resp_valid <= 1'b0;
		end
		else
		begin
			// Store reads come back one cycle after the address,
			// so the buffer load trails the transfer beat by one
			load <= run && !op_write;

			// Reply strobe lasts exactly one cycle
			resp_valid <= 1'b0;

			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						// Remember the operation class for the rest of the packet
						op_write <= (pkt_op == OP_L2_WRITEBACK);
						state    <= ST_TRANSFER;
					end
				end

				ST_TRANSFER:
				begin
					if (last)
						state <= ST_FINISH;
				end

				ST_FINISH:
				begin
					// The last read word lands in the buffer at this edge,
					// so the reply line is complete in the next cycle
					resp_valid <= !op_write;
					state      <= ST_IDLE;
				end

				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/line_beat_counter.sv
/* Line beat counter
   Steps through the words of one line and flags the final beat */
module line_beat_counter
	#(parameter int LINE_WORDS = 16)
	(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          start,
	input  logic                          run,
	output logic [$clog2(LINE_WORDS)-1:0] beat,
	output logic [$clog2(LINE_WORDS)-1:0] load_beat,
	output logic                          last
	);

	// Final word of the line, the controller leaves transfer after it
	assign last = (beat == LINE_WORDS - 1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			beat      <= '0;
			load_beat <= '0;
		end
		else
		begin
			// Read data shows up a cycle late, so keep the beat it belongs to
			load_beat <= beat;

			if (start)
				beat <= '0;
			else if (run)
				beat <= beat + 1'b1;
		end
	end

endmodule

//--- hdl/line_store.sv
/* Word-addressed backing store
   One line transfer port for read or write, plus a registered instruction fetch port */
module line_store
	import ring_mem_pkg::*;
	#(parameter int MEM_WORDS = 4096)
	(
	input  logic                         clk,
	input  logic [$clog2(MEM_WORDS)-1:0] line_index,
	input  logic [$clog2(MEM_WORDS)-1:0] word_offset,
	input  logic                         we,
	input  logic [WORD_BITS-1:0]         wr_word,
	input  logic [$clog2(MEM_WORDS)-1:0] fetch_index,
	output logic [WORD_BITS-1:0]         rd_word,
	output logic [WORD_BITS-1:0]         fetch_word
	);

	logic [WORD_BITS-1:0]         mem [MEM_WORDS];
	logic [$clog2(MEM_WORDS)-1:0] word_index;

	// Memory starts out as all zeros
	initial
	begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = '0;
	end

	// Index width matches the depth, so the sum wraps modulo MEM_WORDS by itself
	assign word_index = line_index + word_offset;

	always_ff @(posedge clk)
	begin
		// Transfer port either writes or reads in a cycle, never both
		if (we)
			mem[word_index] <= wr_word;
		else
			rd_word <= mem[word_index];
	end

	always_ff @(posedge clk)
	begin
		// Fetch reads every cycle and sees the old word on a same-cycle write
		fetch_word <= mem[fetch_index];
	end

endmodule

//--- hdl/line_buffer.sv
/* Line buffer
   Holds writeback data for the store and assembles read words into the reply line */
module line_buffer
	import ring_mem_pkg::*;
	#(parameter int LINE_WORDS = 16)
	(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            capture,
	input  logic                            load,
	input  logic                            op_write,
	input  logic [$clog2(LINE_WORDS)-1:0]   beat,
	input  logic [$clog2(LINE_WORDS)-1:0]   load_beat,
	input  logic [LINE_WORDS*WORD_BITS-1:0] in_line,
	input  logic [WORD_BITS-1:0]            rd_word,
	output logic [WORD_BITS-1:0]            wr_word,
	output logic [LINE_WORDS*WORD_BITS-1:0] line
	);

	// Word slots counted from the bottom of the line vector
	logic [$clog2(LINE_WORDS)-1:0] wr_slot;
	logic [$clog2(LINE_WORDS)-1:0] ld_slot;

	// Word 0 sits in the top bits, so word b lives in slot LINE_WORDS-1-b
	// With a power of two line size that is just the inverted beat
	assign wr_slot = ~beat;
	assign ld_slot = ~load_beat;

	// Write word goes to the store only during writebacks
	// It stays quiet at zero while a read transfer is running
	assign wr_word = op_write ? line[WORD_BITS*wr_slot +: WORD_BITS] : '0;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			line <= '0;
		else if (capture)
			line <= in_line;
		else if (load)
			line[WORD_BITS*ld_slot +: WORD_BITS] <= rd_word;
	end

endmodule

//--- hdl/ring_mem_node.sv
/* Ring memory node top level
   Stands in for the L2 cache: answers line reads, stores writebacks and serves fetches */
module ring_mem_node
	import ring_mem_pkg::*;
	#(
	parameter int LINE_WORDS = 16,
	parameter int MEM_WORDS  = 4096
	)
	(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            pkt_valid,
	input  ring_op_t                        pkt_op,
	input  logic [NODE_BITS-1:0]            pkt_dest,
	input  logic [ADDR_BITS-1:0]            pkt_addr,
	input  logic [LINE_WORDS*WORD_BITS-1:0] pkt_data,
	output logic                            resp_valid,
	output ring_op_t                        resp_op,
	output logic                            resp_ack,
	output logic [NODE_BITS-1:0]            resp_dest,
	output logic [ADDR_BITS-1:0]            resp_addr,
	output logic [LINE_WORDS*WORD_BITS-1:0] resp_data,
	input  logic [ADDR_BITS-1:0]            ifetch_addr,
	output logic [WORD_BITS-1:0]            ifetch_data
	);

	localparam int BEAT_BITS = $clog2(LINE_WORDS);
	localparam int IDX_BITS  = $clog2(MEM_WORDS);

	logic                 start;
	logic                 run;
	logic                 capture;
	logic                 load;
	logic                 op_write;
	logic                 store_we;
	logic                 last;
	logic [BEAT_BITS-1:0] beat;
	logic [BEAT_BITS-1:0] load_beat;
	logic [WORD_BITS-1:0] wr_word;
	logic [WORD_BITS-1:0] rd_word;
	logic [IDX_BITS-1:0]  line_index;
	logic [IDX_BITS-1:0]  word_offset;
	logic [IDX_BITS-1:0]  fetch_index;

	ring_op_t             op_q;
	logic [NODE_BITS-1:0] dest_q;
	logic [ADDR_BITS-1:0] addr_q;

	// Packet header is kept for the whole transfer and echoed in the reply
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			op_q   <= pkt_op;
			dest_q <= pkt_dest;
			addr_q <= pkt_addr;
		end
	end

	// Byte address to word index, with the word-in-line bits cleared
	assign line_index  = {addr_q[2+BEAT_BITS +: IDX_BITS-BEAT_BITS], {BEAT_BITS{1'b0}}};
	assign word_offset = {{(IDX_BITS-BEAT_BITS){1'b0}}, beat};
	assign fetch_index = ifetch_addr[2 +: IDX_BITS];

	// Reply fields, ack is set on every reply that goes out
	assign resp_op   = op_q;
	assign resp_ack  = resp_valid;
	assign resp_dest = dest_q;
	assign resp_addr = addr_q;

	ring_mem_ctrl #(.LINE_WORDS(LINE_WORDS)) u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.pkt_valid  (pkt_valid),
		.pkt_op     (pkt_op),
		.last       (last),
		.start      (start),
		.run        (run),
		.capture    (capture),
		.load       (load),
		.op_write   (op_write),
		.store_we   (store_we),
		.resp_valid (resp_valid)
	);

	line_beat_counter #(.LINE_WORDS(LINE_WORDS)) u_counter (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.run       (run),
		.beat      (beat),
		.load_beat (load_beat),
		.last      (last)
	);

	line_buffer #(.LINE_WORDS(LINE_WORDS)) u_buffer (
		.clk       (clk),
		.rst_n     (rst_n),
		.capture   (capture),
		.load      (load),
		.op_write  (op_write),
		.beat      (beat),
		.load_beat (load_beat),
		.in_line   (pkt_data),
		.rd_word   (rd_word),
		.wr_word   (wr_word),
		.line      (resp_data)
	);

	line_store #(.MEM_WORDS(MEM_WORDS)) u_store (
		.clk         (clk),
		.line_index  (line_index),
		.word_offset (word_offset),
		.we          (store_we),
		.wr_word     (wr_word),
		.fetch_index (fetch_index),
		.rd_word     (rd_word),
		.fetch_word  (ifetch_data)
	);

endmodule

//--- verif/ring_mem_properties.sv
/* Ring memory controller properties
   Packet spacing and strobe rules, bound into the line transfer controller */
module ring_mem_properties
	import ring_mem_pkg::*;
	#(parameter int LINE_WORDS = 16)
	(
	input logic       clk,
	input logic       rst_n,
	input logic       pkt_valid,
	input ring_op_t   pkt_op,
	input logic       start,
	input mem_state_t state,
	input logic       store_we,
	input logic       resp_valid
	);

	// The sender has no back-pressure, so a strobe must never arrive mid transfer
	a_pkt_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		pkt_valid |-> state == ST_IDLE)
		else $error("packet strobe arrived while the controller was busy");

	// Each reply is a single strobe tied to the packet taken LINE_WORDS+2 cycles before
	a_resp_timing: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |-> $past(start, LINE_WORDS + 2))
		else $error("resp_valid not aligned to an accepted packet");

	// Store writes stop right after the last beat of the line
	a_we_window: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(store_we) |-> $past(start, LINE_WORDS + 1))
		else $error("store_we did not span exactly one line of beats");

	// A writeback is silent on the ring
	a_no_wb_reply: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |-> $past(pkt_op, LINE_WORDS + 2) != OP_L2_WRITEBACK)
		else $error("reply sent for a writeback packet");

endmodule

bind ring_mem_ctrl ring_mem_properties #(.LINE_WORDS(LINE_WORDS)) u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.pkt_valid  (pkt_valid),
	.pkt_op     (pkt_op),
	.start      (start),
	.state      (state),
	.store_we   (store_we),
	.resp_valid (resp_valid)
);

//--- verif/tb_ring_mem_node.sv
/* Ring memory node testbench
   Random packets and fetches from an LFSR, checked against a reference memory */
module tb_ring_mem_node
	import ring_mem_pkg::*;
	();

	localparam int LINE_WORDS  = 4;
	localparam int MEM_WORDS   = 256;
	localparam int LINE_BITS   = LINE_WORDS * WORD_BITS;
	localparam int NUM_PKTS    = 300;
	localparam int MIN_GAP     = LINE_WORDS + 3;
	// Gaps run from MIN_GAP to MIN_GAP+3, so 12 cycles per packet covers the worst case
	localparam int CYCLE_LIMIT = NUM_PKTS * 12 + 200;

	logic                 clk;
	logic                 rst_n;
	logic                 pkt_valid;
	ring_op_t             pkt_op;
	logic [NODE_BITS-1:0] pkt_dest;
	logic [ADDR_BITS-1:0] pkt_addr;
	logic [LINE_BITS-1:0] pkt_data;
	logic                 resp_valid;
	ring_op_t             resp_op;
	logic                 resp_ack;
	logic [NODE_BITS-1:0] resp_dest;
	logic [ADDR_BITS-1:0] resp_addr;
	logic [LINE_BITS-1:0] resp_data;
	logic [ADDR_BITS-1:0] ifetch_addr;
	logic [WORD_BITS-1:0] ifetch_data;

	logic [31:0]          lfsr;
	logic [WORD_BITS-1:0] ref_mem [MEM_WORDS];
	int                   cyc;
	int                   run_cycles;
	int                   gap_left;
	int                   pkt_count;
	int                   value_errors;
	int                   resp_errors;
	int                   wb_cyc;
	int unsigned          wb_base;

	// Expected replies, oldest first, with the loop cycle they must show up in
	int                   due_q [$];
	ring_op_t             op_q [$];
	logic [NODE_BITS-1:0] dest_q [$];
	logic [ADDR_BITS-1:0] addr_q [$];
	logic [LINE_BITS-1:0] data_q [$];

	// Fetch expectations travel two cycles, one to the port and one through the read
	logic                 f_chk1;
	logic                 f_chk2;
	logic [WORD_BITS-1:0] f_exp1;
	logic [WORD_BITS-1:0] f_exp2;
	int unsigned          f_idx1;
	int unsigned          f_idx2;

	ring_mem_node #(.LINE_WORDS(LINE_WORDS), .MEM_WORDS(MEM_WORDS)) uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.pkt_valid   (pkt_valid),
		.pkt_op      (pkt_op),
		.pkt_dest    (pkt_dest),
		.pkt_addr    (pkt_addr),
		.pkt_data    (pkt_data),
		.resp_valid  (resp_valid),
		.resp_op     (resp_op),
		.resp_ack    (resp_ack),
		.resp_dest   (resp_dest),
		.resp_addr   (resp_addr),
		.resp_data   (resp_data),
		.ifetch_addr (ifetch_addr),
		.ifetch_data (ifetch_data)
	);

	always #50 clk = ~clk;

	// Galois LFSR, one step for every bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] value;
		int          i;
		value = '0;
		for (i = 0; i < n; i++)
		begin
			value = {value[30:0], lfsr[0]};
			if (lfsr[0])
				lfsr = (lfsr >> 1) ^ 32'h8020_0003;
			else
				lfsr = lfsr >> 1;
		end
		return value;
	endfunction

	// First word index of the line that holds a byte address
	function automatic int unsigned line_base(input logic [ADDR_BITS-1:0] addr);
		int unsigned word;
		word = addr >> 2;
		return (word - word % LINE_WORDS) % MEM_WORDS;
	endfunction

	task automatic drop_expected();
		due_q.delete(0);
		op_q.delete(0);
		dest_q.delete(0);
		addr_q.delete(0);
		data_q.delete(0);
	endtask

	// Outputs are read before the edge updates land, so they hold last cycle's values
	task automatic check_responses();
		if (due_q.size() != 0 && due_q[0] < cyc)
		begin
			$display("Missing response: reply due in cycle %0d never came", due_q[0]);
			resp_errors++;
			drop_expected();
		end
		if (resp_valid)
		begin
			if (due_q.size() == 0 || due_q[0] != cyc)
			begin
				$display("Unexpected response in cycle %0d with no reply due", cyc);
				resp_errors++;
			end
			else
			begin
				if (resp_op !== op_q[0])
				begin
					$display("[ERROR] %0t: resp_op %0d, expected %0d", $time, resp_op, op_q[0]);
					value_errors++;
				end
				if (resp_ack !== 1'b1)
				begin
					$display("[ERROR] %0t: resp_ack low on a reply", $time);
					value_errors++;
				end
				if (resp_dest !== dest_q[0] || resp_addr !== addr_q[0])
				begin
					$display("[ERROR] %0t: resp dest/addr %h/%h, expected %h/%h", $time,
						resp_dest, resp_addr, dest_q[0], addr_q[0]);
					value_errors++;
				end
				if (resp_data !== data_q[0])
				begin
					$display("[ERROR] %0t: resp_data %h, expected %h", $time,
						resp_data, data_q[0]);
					value_errors++;
				end
				drop_expected();
			end
		end
	endtask

	task automatic check_fetch();
		logic [ADDR_BITS-1:0] addr;
		if (f_chk2 && ifetch_data !== f_exp2)
		begin
			$display("[ERROR] %0t: ifetch word %0d is %h, expected %h", $time,
				f_idx2, ifetch_data, f_exp2);
			value_errors++;
		end
		f_chk2 = f_chk1;
		f_exp2 = f_exp1;
		f_idx2 = f_idx1;
		addr = take_bits(ADDR_BITS);
		f_idx1 = (addr >> 2) % MEM_WORDS;
		f_exp1 = ref_mem[f_idx1];
		// Skip words of a line whose writeback is still being written
		f_chk1 = !(cyc > wb_cyc && cyc - wb_cyc <= LINE_WORDS &&
			f_idx1 - f_idx1 % LINE_WORDS == wb_base);
		ifetch_addr <= addr;
	endtask

	task automatic issue_packet();
		logic [31:0]          code;
		ring_op_t             op;
		logic [ADDR_BITS-1:0] addr;
		logic [NODE_BITS-1:0] dest;
		logic [LINE_BITS-1:0] data;
		logic [LINE_BITS-1:0] line_now;
		int unsigned          base;
		int                   w;
		code = take_bits(2);
		case (code)
			32'd1:   op = OP_WRITE_INVALIDATE;
			32'd2:   op = OP_L2_WRITEBACK;
			default: op = OP_READ_SHARED;
		endcase
		// The very first packet reads memory straight out of reset
		if (pkt_count == 0)
			op = OP_READ_SHARED;
		addr = take_bits(ADDR_BITS);
		code = take_bits(NODE_BITS);
		dest = code[NODE_BITS-1:0];
		for (w = 0; w < LINE_WORDS; w++)
			data[WORD_BITS*(LINE_WORDS-1-w) +: WORD_BITS] = take_bits(WORD_BITS);
		base = line_base(addr);
		if (op == OP_L2_WRITEBACK)
		begin
			for (w = 0; w < LINE_WORDS; w++)
				ref_mem[(base + w) % MEM_WORDS] = data[WORD_BITS*(LINE_WORDS-1-w) +: WORD_BITS];
			wb_cyc = cyc;
			wb_base = base;
		end
		else
		begin
			// Word 0 of the reply goes in the top bits
			for (w = 0; w < LINE_WORDS; w++)
				line_now[WORD_BITS*(LINE_WORDS-1-w) +: WORD_BITS] = ref_mem[(base + w) % MEM_WORDS];
			// Strobe is sampled at the next edge, the reply LINE_WORDS+2 cycles later
			due_q.push_back(cyc + 1 + LINE_WORDS + 2);
			op_q.push_back(op);
			dest_q.push_back(dest);
			addr_q.push_back(addr);
			data_q.push_back(line_now);
		end
		pkt_valid <= 1'b1;
		pkt_op    <= op;
		pkt_dest  <= dest;
		pkt_addr  <= addr;
		pkt_data  <= data;
		pkt_count++;
		code = take_bits(2);
		gap_left = MIN_GAP + int'(code);
	endtask

	// Hard stop in case the main loop never finishes
	always @(posedge clk)
	begin
		run_cycles++;
		if (run_cycles > CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		pkt_valid = 1'b0;
		pkt_op = OP_READ_SHARED;
		pkt_dest = '0;
		pkt_addr = '0;
		pkt_data = '0;
		ifetch_addr = '0;
		lfsr = 32'd9;
		cyc = 0;
		run_cycles = 0;
		pkt_count = 0;
		value_errors = 0;
		resp_errors = 0;
		wb_cyc = -100;
		wb_base = 0;
		f_chk1 = 1'b0;
		f_chk2 = 1'b0;
		f_exp1 = '0;
		f_exp2 = '0;
		f_idx1 = 0;
		f_idx2 = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			ref_mem[i] = '0;
		// A few idle cycles after reset to see resp_valid stay low
		gap_left = 5;

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		while (pkt_count < NUM_PKTS || due_q.size() != 0)
		begin
			@(posedge clk);
			cyc++;
			check_responses();
			check_fetch();
			if (pkt_count < NUM_PKTS && gap_left == 0)
				issue_packet();
			else
				pkt_valid <= 1'b0;
			if (gap_left > 0)
				gap_left--;
		end

		$display("Errors: %0d value, %0d response", value_errors, resp_errors);
		if (value_errors + resp_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- project.f
hdl/ring_mem_pkg.sv
hdl/ring_mem_ctrl.sv
hdl/line_beat_counter.sv
hdl/line_store.sv
hdl/line_buffer.sv
hdl/ring_mem_node.sv
verif/ring_mem_properties.sv
verif/tb_ring_mem_node.sv

//--- Makefile
SIM := obj_dir/Vtb_ring_mem_node

.PHONY: run clean

$(SIM): project.f $(wildcard hdl/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_ring_mem_node -o Vtb_ring_mem_node

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
